/* rtl/analog_pkg.sv */
// widths, address map, register offsets, code conversion and bus structs
`default_nettype none

package analog_pkg;

  // ----------------------------------------------------------
  // widths
  // ----------------------------------------------------------
  localparam int ADC_W  = 14;         // converter sample width
  localparam int SUM_W  = ADC_W + 1;  // dac sum before saturation
  localparam int DATA_W = 32;         // apb data width

  // ----------------------------------------------------------
  // address map
  // ----------------------------------------------------------
  localparam int REGION_LSB  = 20;  // region field is paddr[22:20]
  localparam int REGION_BITS = 3;   // eight regions
  localparam int REG_BITS    = 8;   // offset inside a region

  localparam logic [REGION_BITS-1:0] REGION_HK = 3'd0;  // housekeeping
  localparam logic [REGION_BITS-1:0] REGION_FB = 3'd1;  // feedback

  // housekeeping offsets, byte addressed
  localparam logic [REG_BITS-1:0] HK_ID      = 8'h00;
  localparam logic [REG_BITS-1:0] HK_LOOP    = 8'h04;
  localparam logic [REG_BITS-1:0] HK_LED     = 8'h08;
  localparam logic [REG_BITS-1:0] HK_EXP_DIR = 8'h0C;
  localparam logic [REG_BITS-1:0] HK_EXP_OUT = 8'h10;
  localparam logic [REG_BITS-1:0] HK_EXP_IN  = 8'h14;

  // feedback offsets
  localparam logic [REG_BITS-1:0] FB_KP_A  = 8'h00;
  localparam logic [REG_BITS-1:0] FB_KP_B  = 8'h04;
  localparam logic [REG_BITS-1:0] FB_OFF_A = 8'h08;
  localparam logic [REG_BITS-1:0] FB_OFF_B = 8'h0C;

  localparam logic [DATA_W-1:0] BOARD_ID = 32'h5250_0001;  // read-only id word

  // ----------------------------------------------------------
  // types
  // ----------------------------------------------------------
  typedef logic signed [ADC_W-1:0] sample_t;

  typedef struct packed {
    sample_t a;  // channel a
    sample_t b;  // channel b
  } sample_pair_t;

  typedef struct packed {
    logic [31:0]       paddr;
    logic [DATA_W-1:0] pwdata;
    logic              pwrite;
    logic              psel;
    logic              penable;
  } apb_req_t;

  typedef struct packed {
    logic [DATA_W-1:0] prdata;
    logic              pready;
    logic              pslverr;
  } apb_rsp_t;

  // negative-slope code <-> two's complement, the same bit flip both ways
  function automatic sample_t code_flip(input logic [ADC_W-1:0] code);
    return {code[ADC_W-1], ~code[ADC_W-2:0]};
  endfunction

endpackage

`default_nettype wire

/* rtl/apb_region_decoder.sv */
// apb region decoder with one-hot slave select and response multiplexer
`default_nettype none
`timescale 1ns/1ns

module apb_region_decoder (
  input  wire logic                 adc_clk,
  input  wire logic                 arst_n_i,
  input  wire analog_pkg::apb_req_t req_i,     // from the bus master
  output analog_pkg::apb_rsp_t      rsp_o,
  output analog_pkg::apb_req_t      hk_req_o,  // region 0
  output analog_pkg::apb_req_t      fb_req_o,  // region 1
  input  wire analog_pkg::apb_rsp_t hk_rsp_i,
  input  wire analog_pkg::apb_rsp_t fb_rsp_i
);
  import analog_pkg::*;

  localparam int N_REGIONS = 2**REGION_BITS;

  logic [REGION_BITS-1:0] region;
  logic [N_REGIONS-1:0]   region_sel;      // one-hot
  logic                   unmapped;        // no slave behind this region
  logic                   unmapped_acc_q;  // next cycle is an unmapped access phase

  assign region     = req_i.paddr[REGION_LSB +: REGION_BITS];
  assign region_sel = N_REGIONS'(1) << region;
  assign unmapped   = ~(region_sel[REGION_HK] | region_sel[REGION_FB]);

  // ----------------------------------------------------------
  // request fan-out, only psel is steered
  // ----------------------------------------------------------
  always_comb begin
    hk_req_o      = req_i;
    hk_req_o.psel = req_i.psel & region_sel[REGION_HK];
    fb_req_o      = req_i;
    fb_req_o.psel = req_i.psel & region_sel[REGION_FB];
  end

  // flag set in the setup phase, gone after the single access cycle
  always_ff @(posedge adc_clk or negedge arst_n_i) begin
    if (!arst_n_i) begin
      unmapped_acc_q <= 1'b0;
    end else begin
      unmapped_acc_q <= req_i.psel & ~req_i.penable & unmapped;
    end
  end

  // ----------------------------------------------------------
  // return path
  // ----------------------------------------------------------
  always_comb begin
    rsp_o = '0;  // idle bus answers all zero
    if (req_i.psel) begin
      if (region_sel[REGION_HK]) begin
        rsp_o = hk_rsp_i;
      end else if (region_sel[REGION_FB]) begin
        rsp_o = fb_rsp_i;
      end else begin
        rsp_o.pready = unmapped_acc_q & req_i.penable;  // zero data, always ack
      end
    end
  end

endmodule

`default_nettype wire

/* rtl/housekeeping_regs.sv */
// housekeeping apb slave with id, loopback, led and expansion registers
`default_nettype none
`timescale 1ns/1ns

module housekeeping_regs #(
  parameter int EXP_W = 8  // expansion port width
) (
  input  wire logic                 adc_clk,
  input  wire logic                 arst_n_i,
  input  wire analog_pkg::apb_req_t req_i,
  output analog_pkg::apb_rsp_t      rsp_o,
  input  wire logic [EXP_W-1:0]     exp_in_i,   // async pins
  output logic      [EXP_W-1:0]     exp_out_o,
  output logic      [EXP_W-1:0]     exp_dir_o,  // 1 = output
  output logic      [7:0]           led_o,
  output logic                      loop_o      // digital loopback
);
  import analog_pkg::*;

  logic [REG_BITS-1:0] reg_addr;
  logic                acc;     // access phase of this slave
  logic                wr_en;
  logic [DATA_W-1:0]   rd_data;

  logic             loop_q;
  logic [7:0]       led_q;
  logic [EXP_W-1:0] exp_dir_q;
  logic [EXP_W-1:0] exp_out_q;
  logic [EXP_W-1:0] exp_meta_q;  // first sync stage
  logic [EXP_W-1:0] exp_sync_q;  // second sync stage

  assign reg_addr = req_i.paddr[REG_BITS-1:0];
  assign acc      = req_i.psel & req_i.penable;
  assign wr_en    = acc & req_i.pwrite;  // commits at the completing edge

  // ----------------------------------------------------------
  // control registers
  // ----------------------------------------------------------
  always_ff @(posedge adc_clk or negedge arst_n_i) begin
    if (!arst_n_i) begin
      loop_q    <= 1'b0;
      led_q     <= '0;
      exp_dir_q <= '0;
      exp_out_q <= '0;
    end else if (wr_en) begin
      case (reg_addr)
        HK_LOOP:    loop_q    <= req_i.pwdata[0];
        HK_LED:     led_q     <= req_i.pwdata[7:0];
        HK_EXP_DIR: exp_dir_q <= req_i.pwdata[EXP_W-1:0];
        HK_EXP_OUT: exp_out_q <= req_i.pwdata[EXP_W-1:0];
        default:    ;  // id and inputs are read only
      endcase
    end
  end

  // two-flop synchronizer on the expansion inputs
  always_ff @(posedge adc_clk or negedge arst_n_i) begin
    if (!arst_n_i) begin
      exp_meta_q <= '0;
      exp_sync_q <= '0;
    end else begin
      exp_meta_q <= exp_in_i;
      exp_sync_q <= exp_meta_q;
    end
  end

  // ----------------------------------------------------------
  // read path, no wait states
  // ----------------------------------------------------------
  always_comb begin
    case (reg_addr)
      HK_ID:      rd_data = BOARD_ID;
      HK_LOOP:    rd_data = DATA_W'(loop_q);
      HK_LED:     rd_data = DATA_W'(led_q);
      HK_EXP_DIR: rd_data = DATA_W'(exp_dir_q);
      HK_EXP_OUT: rd_data = DATA_W'(exp_out_q);
      HK_EXP_IN:  rd_data = DATA_W'(exp_sync_q);
      default:    rd_data = '0;  // undefined offsets read zero
    endcase
  end

  always_comb begin
    rsp_o.prdata  = (acc & ~req_i.pwrite) ? rd_data : '0;
    rsp_o.pready  = acc;
    rsp_o.pslverr = 1'b0;
  end

  assign loop_o    = loop_q;
  assign led_o     = led_q;
  assign exp_dir_o = exp_dir_q;
  assign exp_out_o = exp_out_q;

endmodule

`default_nettype wire

/* rtl/adc_frontend.sv */
// adc input registers, negative-slope conversion and loopback select
`default_nettype none
`timescale 1ns/1ns

module adc_frontend (
  input  wire logic [analog_pkg::ADC_W-1:0] adc_dat_a_i,  // raw code ch a
  input  wire logic [analog_pkg::ADC_W-1:0] adc_dat_b_i,  // raw code ch b
  input  wire logic                         adc_clk,
  input  wire logic                         arst_n_i,
  input  wire logic                         loop_i,       // take the dac sum
  input  wire analog_pkg::sample_pair_t     dac_sum_i,
  output analog_pkg::sample_pair_t          samples_o
);
  import analog_pkg::*;

  logic [ADC_W-1:0] adc_a_q;  // io registers
  logic [ADC_W-1:0] adc_b_q;

  always_ff @(posedge adc_clk or negedge arst_n_i) begin
    if (!arst_n_i) begin
      adc_a_q <= '0;
      adc_b_q <= '0;
    end else begin
      adc_a_q <= adc_dat_a_i;
      adc_b_q <= adc_dat_b_i;
    end
  end

  // ----------------------------------------------------------
  // conversion and loopback are combinational
  // ----------------------------------------------------------
  always_comb begin
    if (loop_i) begin
      samples_o = dac_sum_i;  // digital loopback from the dac side
    end else begin
      samples_o.a = code_flip(adc_a_q);  // keep msb, invert the rest
      samples_o.b = code_flip(adc_b_q);
    end
  end

endmodule

`default_nettype wire

/* rtl/prop_feedback.sv */
// feedback apb slave with gain and offset registers and the proportional path
`default_nettype none
`timescale 1ns/1ns

module prop_feedback #(
  parameter int KP_SHIFT = 12  // 4096 is unity gain
) (
  input  wire logic                     adc_clk,
  input  wire logic                     arst_n_i,
  input  wire analog_pkg::apb_req_t     req_i,
  output analog_pkg::apb_rsp_t          rsp_o,
  input  wire analog_pkg::sample_pair_t samples_i,
  output analog_pkg::sample_pair_t      fb_o,      // registered feedback result
  output analog_pkg::sample_pair_t      offset_o   // stands in for the generator
);
  import analog_pkg::*;

  localparam int KP_W   = 16;            // signed gain width
  localparam int PROD_W = ADC_W + KP_W;  // full product

  logic [REG_BITS-1:0] reg_addr;
  logic                acc;
  logic                wr_en;
  logic [DATA_W-1:0]   rd_data;

  logic signed [KP_W-1:0]   kp_a_q;
  logic signed [KP_W-1:0]   kp_b_q;
  sample_t                  off_a_q;
  sample_t                  off_b_q;
  logic signed [PROD_W-1:0] prod_a;
  logic signed [PROD_W-1:0] prod_b;
  sample_pair_t             fb_q;

  // clip a shifted product to the sample range
  function automatic sample_t sat_prod(input logic signed [PROD_W-1:0] v);
    logic [PROD_W-ADC_W:0] top;  // bits that must all match the sign
    top = v[PROD_W-1:ADC_W-1];
    if (&top || ~|top) begin
      return v[ADC_W-1:0];
    end
    return {v[PROD_W-1], {(ADC_W-1){~v[PROD_W-1]}}};
  endfunction

  assign reg_addr = req_i.paddr[REG_BITS-1:0];
  assign acc      = req_i.psel & req_i.penable;
  assign wr_en    = acc & req_i.pwrite;

  // ----------------------------------------------------------
  // gain and offset registers
  // ----------------------------------------------------------
  always_ff @(posedge adc_clk or negedge arst_n_i) begin
    if (!arst_n_i) begin
      kp_a_q  <= '0;
      kp_b_q  <= '0;
      off_a_q <= '0;
      off_b_q <= '0;
    end else if (wr_en) begin
      case (reg_addr)
        FB_KP_A:  kp_a_q  <= req_i.pwdata[KP_W-1:0];
        FB_KP_B:  kp_b_q  <= req_i.pwdata[KP_W-1:0];
        FB_OFF_A: off_a_q <= req_i.pwdata[ADC_W-1:0];
        FB_OFF_B: off_b_q <= req_i.pwdata[ADC_W-1:0];
        default:  ;
      endcase
    end
  end

  // readback is sign extended
  always_comb begin
    case (reg_addr)
      FB_KP_A:  rd_data = {{(DATA_W-KP_W){kp_a_q[KP_W-1]}}, kp_a_q};
      FB_KP_B:  rd_data = {{(DATA_W-KP_W){kp_b_q[KP_W-1]}}, kp_b_q};
      FB_OFF_A: rd_data = {{(DATA_W-ADC_W){off_a_q[ADC_W-1]}}, off_a_q};
      FB_OFF_B: rd_data = {{(DATA_W-ADC_W){off_b_q[ADC_W-1]}}, off_b_q};
      default:  rd_data = '0;
    endcase
  end

  always_comb begin
    rsp_o.prdata  = (acc & ~req_i.pwrite) ? rd_data : '0;
    rsp_o.pready  = acc;
    rsp_o.pslverr = 1'b0;
  end

  // ----------------------------------------------------------
  // proportional path, one registered stage
  // ----------------------------------------------------------
  assign prod_a = $signed(samples_i.a) * kp_a_q;
  assign prod_b = $signed(samples_i.b) * kp_b_q;

  always_ff @(posedge adc_clk or negedge arst_n_i) begin
    if (!arst_n_i) begin
      fb_q <= '0;
    end else begin
      fb_q.a <= sat_prod(prod_a >>> KP_SHIFT);  // arithmetic shift keeps sign
      fb_q.b <= sat_prod(prod_b >>> KP_SHIFT);
    end
  end

  assign fb_o       = fb_q;
  assign offset_o.a = off_a_q;
  assign offset_o.b = off_b_q;

endmodule

`default_nettype wire

/* rtl/dac_backend.sv */
// dac sum with saturation, negative-slope conversion and output registers
`default_nettype none
`timescale 1ns/1ns

module dac_backend (
  input  wire logic                         adc_clk,
  input  wire logic                         arst_n_i,
  input  wire analog_pkg::sample_pair_t     fb_i,
  input  wire analog_pkg::sample_pair_t     offset_i,
  output analog_pkg::sample_pair_t          dac_sum_o,    // saturated, for loopback
  output logic [analog_pkg::ADC_W-1:0]      dac_dat_a_o,  // neg-slope code
  output logic [analog_pkg::ADC_W-1:0]      dac_dat_b_o
);
  import analog_pkg::*;

  localparam logic [ADC_W-1:0] DAC_ZERO = {1'b0, {(ADC_W-1){1'b1}}};  // code for 0

  logic signed [SUM_W-1:0] sum_a;
  logic signed [SUM_W-1:0] sum_b;
  sample_pair_t            sat;
  logic [ADC_W-1:0]        dac_a_q;
  logic [ADC_W-1:0]        dac_b_q;

  // top two bits differ means the sum left the sample range
  function automatic sample_t sat_sum(input logic signed [SUM_W-1:0] s);
    if (^s[SUM_W-1:SUM_W-2]) begin
      return {s[SUM_W-1], {(ADC_W-1){~s[SUM_W-1]}}};
    end
    return s[ADC_W-1:0];
  endfunction

  // ----------------------------------------------------------
  // sum and saturation
  // ----------------------------------------------------------
  assign sum_a = $signed({fb_i.a[ADC_W-1], fb_i.a}) + $signed({offset_i.a[ADC_W-1], offset_i.a});
  assign sum_b = $signed({fb_i.b[ADC_W-1], fb_i.b}) + $signed({offset_i.b[ADC_W-1], offset_i.b});

  assign sat.a     = sat_sum(sum_a);
  assign sat.b     = sat_sum(sum_b);
  assign dac_sum_o = sat;

  // output registers, back to negative slope
  always_ff @(posedge adc_clk or negedge arst_n_i) begin
    if (!arst_n_i) begin
      dac_a_q <= DAC_ZERO;
      dac_b_q <= DAC_ZERO;
    end else begin
      dac_a_q <= code_flip(sat.a);
      dac_b_q <= code_flip(sat.b);
    end
  end

  assign dac_dat_a_o = dac_a_q;
  assign dac_dat_b_o = dac_b_q;

endmodule

`default_nettype wire

/* rtl/analog_top.sv */
// analog core top level with bus decoder, housekeeping, adc, feedback and dac
`default_nettype none
`timescale 1ns/1ns

module analog_top #(
  parameter int EXP_W    = 8,   // expansion port width
  parameter int KP_SHIFT = 12   // gain shift in the feedback block
) (
  input  wire logic                         adc_clk,
  input  wire logic                         arst_n_i,
  // system bus
  input  wire analog_pkg::apb_req_t         apb_req_i,
  output analog_pkg::apb_rsp_t              apb_rsp_o,
  // converters
  input  wire logic [analog_pkg::ADC_W-1:0] adc_dat_a_i,
  input  wire logic [analog_pkg::ADC_W-1:0] adc_dat_b_i,
  output logic      [analog_pkg::ADC_W-1:0] dac_dat_a_o,
  output logic      [analog_pkg::ADC_W-1:0] dac_dat_b_o,
  // board io
  input  wire logic [EXP_W-1:0]             exp_in_i,
  output logic      [EXP_W-1:0]             exp_out_o,
  output logic      [EXP_W-1:0]             exp_dir_o,
  output logic      [7:0]                   led_o
);
  import analog_pkg::*;

  apb_req_t     hk_req;
  apb_req_t     fb_req;
  apb_rsp_t     hk_rsp;
  apb_rsp_t     fb_rsp;
  logic         loop;      // digital loopback enable
  sample_pair_t samples;   // converted adc, or dac sum in loopback
  sample_pair_t fb;        // feedback result
  sample_pair_t offset;    // per-channel dc offset
  sample_pair_t dac_sum;   // saturated sum

  // ----------------------------------------------------------
  // bus
  // ----------------------------------------------------------
  apb_region_decoder u_decoder (
    .adc_clk  (adc_clk),
    .arst_n_i (arst_n_i),
    .req_i    (apb_req_i),
    .rsp_o    (apb_rsp_o),
    .hk_req_o (hk_req),
    .fb_req_o (fb_req),
    .hk_rsp_i (hk_rsp),
    .fb_rsp_i (fb_rsp)
  );

  housekeeping_regs #(.EXP_W(EXP_W)) u_hk (  // region 0
    .adc_clk   (adc_clk),
    .arst_n_i  (arst_n_i),
    .req_i     (hk_req),
    .rsp_o     (hk_rsp),
    .exp_in_i  (exp_in_i),
    .exp_out_o (exp_out_o),
    .exp_dir_o (exp_dir_o),
    .led_o     (led_o),
    .loop_o    (loop)
  );

  // ----------------------------------------------------------
  // sample path, pins to pins in 3 cycles
  // ----------------------------------------------------------
  adc_frontend u_adc (
    .adc_dat_a_i (adc_dat_a_i),
    .adc_dat_b_i (adc_dat_b_i),
    .adc_clk     (adc_clk),
    .arst_n_i    (arst_n_i),
    .loop_i      (loop),
    .dac_sum_i   (dac_sum),
    .samples_o   (samples)
  );

  prop_feedback #(.KP_SHIFT(KP_SHIFT)) u_fb (  // region 1
    .adc_clk   (adc_clk),
    .arst_n_i  (arst_n_i),
    .req_i     (fb_req),
    .rsp_o     (fb_rsp),
    .samples_i (samples),
    .fb_o      (fb),
    .offset_o  (offset)
  );

  dac_backend u_dac (
    .adc_clk     (adc_clk),
    .arst_n_i    (arst_n_i),
    .fb_i        (fb),
    .offset_i    (offset),
    .dac_sum_o   (dac_sum),
    .dac_dat_a_o (dac_dat_a_o),
    .dac_dat_b_o (dac_dat_b_o)
  );

endmodule

`default_nettype wire

/* testbench/analog_top_asserts.sv */
// bound concurrent assertions on the apb handshake, dac outputs and led reset state
`default_nettype none
`timescale 1ns/1ns

module analog_top_asserts (
  input wire logic                         adc_clk,
  input wire logic                         arst_n_i,
  input wire analog_pkg::apb_req_t         apb_req_i,
  input wire analog_pkg::apb_rsp_t         apb_rsp_o,
  input wire logic [analog_pkg::ADC_W-1:0] dac_dat_a_o,
  input wire logic [analog_pkg::ADC_W-1:0] dac_dat_b_o,
  input wire logic [7:0]                   led_o
);

  int fail_cnt = 0;  // read by the testbench at the end

  // ready only ever in an access phase
  pready_in_access: assert property (@(posedge adc_clk) disable iff (!arst_n_i)
    apb_rsp_o.pready |-> (apb_req_i.psel && apb_req_i.penable))
    else begin
      fail_cnt++;
      $error("pready seen outside an apb access phase");
    end

  // dac pins fully driven once out of reset
  dac_known: assert property (@(posedge adc_clk) disable iff (!arst_n_i)
    !$isunknown({dac_dat_a_o, dac_dat_b_o}))
    else begin
      fail_cnt++;
      $error("dac output unknown after reset");
    end

  led_reset: assert property (@(posedge adc_clk) !arst_n_i |-> (led_o == 8'h00))
    else begin
      fail_cnt++;
      $error("led_o not zero during reset");
    end

endmodule

bind analog_top analog_top_asserts u_asserts (
  .adc_clk     (adc_clk),
  .arst_n_i    (arst_n_i),
  .apb_req_i   (apb_req_i),
  .apb_rsp_o   (apb_rsp_o),
  .dac_dat_a_o (dac_dat_a_o),
  .dac_dat_b_o (dac_dat_b_o),
  .led_o       (led_o)
);

`default_nettype wire

/* testbench/tb_analog_top.sv */
// testbench for the analog core with apb tasks, reference model and directed tests
`default_nettype none
`timescale 1ns/1ns

module tb_analog_top;
  import analog_pkg::*;

  localparam int          EXP_W          = 8;
  localparam int          KP_SHIFT       = 12;  // 4096 = unity
  localparam int          HALF_PERIOD    = 20;  // 40 ns clock
  localparam int          PREADY_TIMEOUT = 16;  // cycles
  localparam int          SETTLE         = 8;   // cycles before a dac check
  localparam longint      S_MAX          = longint'(2**(ADC_W-1)) - 1;
  localparam longint      S_MIN          = -longint'(2**(ADC_W-1));
  localparam logic [31:0] HK_BASE        = 32'h0000_0000;  // region 0
  localparam logic [31:0] FB_BASE        = 32'h0010_0000;  // region 1

  logic             adc_clk;
  logic             arst_n_i;
  apb_req_t         req;
  apb_rsp_t         rsp;
  logic [ADC_W-1:0] adc_a;
  logic [ADC_W-1:0] adc_b;
  logic [ADC_W-1:0] dac_a;
  logic [ADC_W-1:0] dac_b;
  logic [EXP_W-1:0] exp_in;
  logic [EXP_W-1:0] exp_out;
  logic [EXP_W-1:0] exp_dir;
  logic [7:0]       led;
  int               errors;
  int               tests_run;
  int               tests_ok;
  int               seed;

  analog_top #(.EXP_W(EXP_W), .KP_SHIFT(KP_SHIFT)) dut (
    .adc_clk     (adc_clk),
    .arst_n_i    (arst_n_i),
    .apb_req_i   (req),
    .apb_rsp_o   (rsp),
    .adc_dat_a_i (adc_a),
    .adc_dat_b_i (adc_b),
    .dac_dat_a_o (dac_a),
    .dac_dat_b_o (dac_b),
    .exp_in_i    (exp_in),
    .exp_out_o   (exp_out),
    .exp_dir_o   (exp_dir),
    .led_o       (led)
  );

  always #HALF_PERIOD adc_clk = ~adc_clk;

  // ------------------------------------------------------------
  // reference model
  // ------------------------------------------------------------
  // two's complement -> negative-slope code, msb kept
  function automatic logic [ADC_W-1:0] to_code(input int v);
    logic [ADC_W-1:0] t;
    t = v[ADC_W-1:0];
    return t ^ {1'b0, {(ADC_W-1){1'b1}}};
  endfunction

  function automatic int from_code(input logic [ADC_W-1:0] c);
    logic [ADC_W-1:0] t;
    t = c ^ {1'b0, {(ADC_W-1){1'b1}}};
    return int'($signed(t));
  endfunction

  function automatic int clip(input longint v);
    if (v > S_MAX) return int'(S_MAX);
    if (v < S_MIN) return int'(S_MIN);
    return int'(v);
  endfunction

  // pin code -> gain, shift, clip -> plus offset, clip -> dac code
  function automatic logic [ADC_W-1:0] model_dac(input logic [ADC_W-1:0] pin,
                                                  input int kp, input int off);
    longint prod;
    prod = longint'(from_code(pin)) * longint'(kp);
    prod = prod >>> KP_SHIFT;
    return to_code(clip(longint'(clip(prod)) + longint'(off)));
  endfunction

  // ------------------------------------------------------------
  // bus and check helpers
  // ------------------------------------------------------------
  task automatic apb_xfer(input logic [31:0] addr, input logic [31:0] wdata,
                          input logic write, output logic [31:0] rdata);
    int n;
    @(negedge adc_clk);  // setup phase
    req.paddr   = addr;
    req.pwdata  = wdata;
    req.pwrite  = write;
    req.psel    = 1'b1;
    req.penable = 1'b0;
    @(negedge adc_clk);  // access phase
    req.penable = 1'b1;
    n = 0;
    #1;
    while (!rsp.pready && n < PREADY_TIMEOUT) begin
      @(negedge adc_clk);
      #1;
      n++;
    end
    rdata = rsp.prdata;  // sampled mid low phase, stable
    if (!rsp.pready) begin
      $display("ERROR at %0t: no pready within %0d cycles for address %h",
               $time, PREADY_TIMEOUT, addr);
      errors++;
    end else begin
      check("wait states", 32'(n), 32'h0);  // ready in the first access cycle
      check("pslverr", 32'(rsp.pslverr), 32'h0);
    end
    @(negedge adc_clk);  // completing edge lies just behind
    req.psel    = 1'b0;
    req.penable = 1'b0;
    req.pwrite  = 1'b0;
  endtask

  task automatic apb_write(input logic [31:0] addr, input logic [31:0] data);
    logic [31:0] unused_rd;
    apb_xfer(addr, data, 1'b1, unused_rd);
  endtask

  task automatic apb_read(input logic [31:0] addr, output logic [31:0] data);
    apb_xfer(addr, 32'h0, 1'b0, data);
  endtask

  task automatic check(input string what, input logic [31:0] got, input logic [31:0] exp);
    assert (got === exp) else begin
      $display("CHECK FAILED at %0t: %s got %h expected %h", $time, what, got, exp);
      errors++;
    end
  endtask

  task automatic drive_pins(input logic [ADC_W-1:0] a, input logic [ADC_W-1:0] b);
    @(negedge adc_clk);
    adc_a = a;
    adc_b = b;
  endtask

  task automatic settle();  // bounded by the pipeline depth
    repeat (SETTLE) @(negedge adc_clk);
  endtask

  task automatic set_channels(input int kp_a, input int kp_b, input int off_a, input int off_b);
    apb_write(FB_BASE | 32'(FB_KP_A), kp_a);
    apb_write(FB_BASE | 32'(FB_KP_B), kp_b);
    apb_write(FB_BASE | 32'(FB_OFF_A), off_a);
    apb_write(FB_BASE | 32'(FB_OFF_B), off_b);
  endtask

  task automatic report(input string name, input int e0);
    tests_run++;
    if (errors == e0) tests_ok++;
    $display("test %-24s %s (%0d errors)", name, (errors == e0) ? "ok" : "bad", errors - e0);
  endtask

  // ------------------------------------------------------------
  // directed tests
  // ------------------------------------------------------------
  task automatic reset_state();
    int e0;
    e0 = errors;
    check("led", 32'(led), 32'h0);
    check("exp dir", 32'(exp_dir), 32'h0);
    check("exp out", 32'(exp_out), 32'h0);
    check("dac a zero code", 32'(dac_a), 32'(to_code(0)));
    check("dac b zero code", 32'(dac_b), 32'(to_code(0)));
    check("idle prdata", rsp.prdata, 32'h0);
    check("idle ready and error", 32'({rsp.pready, rsp.pslverr}), 32'h0);
    report("reset state", e0);
  endtask

  task automatic read_id_and_unmapped();
    int          e0;
    logic [31:0] d;
    logic [31:0] r;
    e0 = errors;
    apb_read(HK_BASE | 32'(HK_ID), d);
    check("board id", d, BOARD_ID);
    for (int reg_n = 2; reg_n < 8; reg_n++) begin
      r = $random(seed);
      apb_read((32'(reg_n) << REGION_LSB) | {24'h0, r[7:2], 2'b00}, d);
      check($sformatf("region %0d read", reg_n), d, 32'h0);
    end
    report("id and unmapped", e0);
  endtask

  task automatic board_io_regs();
    int          e0;
    logic [31:0] d;
    e0 = errors;
    apb_write(HK_BASE | 32'(HK_LED), 32'h0000_00A5);
    apb_write(HK_BASE | 32'(HK_EXP_DIR), 32'h0000_003C);
    apb_write(HK_BASE | 32'(HK_EXP_OUT), 32'h0000_0096);
    check("led pins", 32'(led), 32'h0000_00A5);
    check("exp dir pins", 32'(exp_dir), 32'h0000_003C);
    check("exp out pins", 32'(exp_out), 32'h0000_0096);
    apb_read(HK_BASE | 32'(HK_LED), d);
    check("led readback", d, 32'h0000_00A5);
    apb_read(HK_BASE | 32'(HK_EXP_DIR), d);
    check("exp dir readback", d, 32'h0000_003C);
    apb_read(HK_BASE | 32'(HK_EXP_OUT), d);
    check("exp out readback", d, 32'h0000_0096);
    @(negedge adc_clk);
    exp_in = 8'h5A;
    repeat (3) @(negedge adc_clk);  // through the synchronizer
    apb_read(HK_BASE | 32'(HK_EXP_IN), d);
    check("exp in read", d, 32'h0000_005A);
    report("board io", e0);
  endtask

  task automatic offset_only_path();
    int          e0;
    logic [31:0] d;
    e0 = errors;
    set_channels(0, 0, 1234, -2000);
    settle();
    check("offset a dac", 32'(dac_a), 32'(to_code(1234)));
    check("offset b dac", 32'(dac_b), 32'(to_code(-2000)));
    apb_read(FB_BASE | 32'(FB_OFF_B), d);
    check("offset b readback", d, 32'(-2000));  // sign extended
    report("offset only", e0);
  endtask

  task automatic random_gain_path();
    int          e0;
    int          kp_a;
    int          kp_b;
    int          off_a;
    int          off_b;
    logic [31:0] r;
    e0 = errors;
    for (int i = 0; i < 6; i++) begin
      kp_a  = $random(seed) % 8192;
      kp_b  = $random(seed) % 8192;
      off_a = $random(seed) % 4096;
      off_b = $random(seed) % 4096;
      r     = $random(seed);
      set_channels(kp_a, kp_b, off_a, off_b);
      drive_pins(r[13:0], r[29:16]);
      settle();
      check($sformatf("rand %0d dac a", i), 32'(dac_a), 32'(model_dac(r[13:0], kp_a, off_a)));
      check($sformatf("rand %0d dac b", i), 32'(dac_b), 32'(model_dac(r[29:16], kp_b, off_b)));
    end
    report("random gain", e0);
  endtask

  task automatic saturate_sum();
    int e0;
    e0 = errors;
    set_channels(4096, 4096, 8000, -8000);
    drive_pins(to_code(1000), to_code(-1000));  // pushes each sum past the rail
    settle();
    check("sat high", 32'(dac_a), 32'(to_code(int'(S_MAX))));
    check("sat low", 32'(dac_b), 32'(to_code(int'(S_MIN))));
    report("saturation", e0);
  endtask

  task automatic loopback_full_scale();
    int          e0;
    logic [31:0] r;
    e0 = errors;
    set_channels(4096, 4096, 4000, 4000);
    r     = $random(seed);
    r[13] = 1'b1;  // negative samples, only loopback reaches the rail
    r[29] = 1'b1;
    drive_pins(r[13:0], r[29:16]);
    apb_write(HK_BASE | 32'(HK_LOOP), 32'h1);
    settle();  // sum climbs by the offset each cycle
    check("loop dac a", 32'(dac_a), 32'(to_code(int'(S_MAX))));
    check("loop dac b", 32'(dac_b), 32'(to_code(int'(S_MAX))));
    apb_write(HK_BASE | 32'(HK_LOOP), 32'h0);
    settle();
    check("pins dac a", 32'(dac_a), 32'(model_dac(r[13:0], 4096, 4000)));
    check("pins dac b", 32'(dac_b), 32'(model_dac(r[29:16], 4096, 4000)));
    report("loopback", e0);
  endtask

  // ------------------------------------------------------------
  // main sequence
  // ------------------------------------------------------------
  initial begin
    adc_clk   = 1'b0;
    arst_n_i  = 1'b0;
    req       = '0;
    adc_a     = '0;
    adc_b     = '0;
    exp_in    = '0;
    errors    = 0;
    tests_run = 0;
    tests_ok  = 0;
    seed      = 32'h007f_00f7;
    repeat (2) @(posedge adc_clk);
    @(negedge adc_clk);
    arst_n_i = 1'b1;
    reset_state();
    read_id_and_unmapped();
    board_io_regs();
    offset_only_path();
    random_gain_path();
    saturate_sum();
    loopback_full_scale();
    errors = errors + dut.u_asserts.fail_cnt;  // bound assertion failures
    $display("tests %0d, passed %0d, errors %0d", tests_run, tests_ok, errors);
    if (errors == 0) begin
      $display("*** PASSED ***");
    end else begin
      $display("*** FAILED ***");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* verilog.f */
rtl/analog_pkg.sv
rtl/apb_region_decoder.sv
rtl/housekeeping_regs.sv
rtl/adc_frontend.sv
rtl/prop_feedback.sv
rtl/dac_backend.sv
rtl/analog_top.sv
testbench/analog_top_asserts.sv
testbench/tb_analog_top.sv

/* Makefile */
TOP = tb_analog_top

all: build run

build:
	verilator --binary --timing --assert -f verilog.f --top-module $(TOP) -o $(TOP)

run: build
	./obj_dir/$(TOP) +verilator+error+limit+1000 | tee sim.log
	grep -qF "*** PASSED ***" sim.log

lint:
	verilator --lint-only --timing -f verilog.f --top-module $(TOP)

clean:
	rm -rf obj_dir sim.log

.PHONY: all build run lint clean
